/* src/l2_geom_pkg.sv */
`default_nettype none

// geometry of the second-level cache and the address split it implies.
// an address is {tag, index, offset}, with the offset selecting a byte in a line.
package l2_geom_pkg;

    localparam int unsigned addr_width = 16;
    localparam int unsigned offset_bits = 4;
    localparam int unsigned index_bits = 3;
    localparam int unsigned tag_bits = addr_width - index_bits - offset_bits;

    localparam int unsigned num_sets = 1 << index_bits;
    localparam int unsigned num_ways = 8;
    localparam int unsigned way_bits = $clog2(num_ways);

    localparam int unsigned line_width = 8 << offset_bits;

    // a binary tree over the ways has one node fewer than it has leaves.
    localparam int unsigned plru_bits = num_ways - 1;

    typedef logic [addr_width-1:0] l2_addr_t;

    typedef logic [line_width-1:0] l2_line_t;

    typedef logic [tag_bits-1:0] l2_tag_t;

    typedef logic [index_bits-1:0] l2_index_t;

    typedef logic [way_bits-1:0] l2_way_t;

endpackage : l2_geom_pkg

`default_nettype wire

/* src/l2_ctl_pkg.sv */
`default_nettype none

// encodings shared by the cache controller and the cache datapath.
package l2_ctl_pkg;

    typedef enum logic [1:0] {
        s_check     = 2'd0,
        s_writeback = 2'd1,
        s_fill      = 2'd2
    } l2_state_e;

    // a way command loads the valid and dirty bits from v_in and d_in.
    typedef struct packed {
        logic load_v;
        logic load_d;
        logic load_td;
        logic v_in;
        logic d_in;
    } l2_way_ctl_t;

    typedef struct packed {
        logic hit;
        logic dirty;
    } l2_way_stat_t;

    // source of the physical memory address.
    typedef enum logic {
        sel_req_addr   = 1'b0,
        sel_victim_tag = 1'b1
    } l2_sel_e;

endpackage : l2_ctl_pkg

`default_nettype wire

/* src/l2_ctl_if.sv */
`timescale 1ns/10ps
`default_nettype none

// commands from the controller to the datapath and status going back.
interface l2_ctl_if;

    l2_ctl_pkg::l2_way_ctl_t [l2_geom_pkg::num_ways-1:0] way_ctl;
    logic load_lru;
    logic wdata_from_mem;
    l2_ctl_pkg::l2_sel_e addr_sel;

    l2_ctl_pkg::l2_way_stat_t [l2_geom_pkg::num_ways-1:0] way_stat;
    l2_geom_pkg::l2_way_t victim;

    modport ctrl (
        output way_ctl,
        output load_lru,
        output wdata_from_mem,
        output addr_sel,
        input  way_stat,
        input  victim
    );

    modport dp (
        input  way_ctl,
        input  load_lru,
        input  wdata_from_mem,
        input  addr_sel,
        output way_stat,
        output victim
    );

endinterface : l2_ctl_if

`default_nettype wire

/* src/l2_array.sv */
`timescale 1ns/10ps
`default_nettype none

// one entry per set. the read is combinational and a write lands on the next edge.
module l2_array #(
    parameter bit clear_on_rst = 1'b0,
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic write,
    input  l2_geom_pkg::l2_index_t index,
    input  T datain,
    output T dataout
);

    T mem [l2_geom_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (clear_on_rst && rst) begin
            for (int i = 0; i < l2_geom_pkg::num_sets; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            mem[index] <= datain;
        end
    end

    assign dataout = mem[index];

endmodule : l2_array

`default_nettype wire

/* src/l2_way.sv */
`timescale 1ns/10ps
`default_nettype none

// one way of the cache holds valid, dirty, tag and line for every set.
module l2_way (
    input  logic clk,
    input  logic rst,
    input  l2_ctl_pkg::l2_way_ctl_t ctl,
    input  l2_geom_pkg::l2_index_t index,
    input  l2_geom_pkg::l2_tag_t tag_in,
    input  l2_geom_pkg::l2_line_t data_in,
    output logic v_out,
    output logic d_out,
    output l2_geom_pkg::l2_tag_t tag_out,
    output l2_geom_pkg::l2_line_t data_out
);

    // flag bits start cleared so that no stale line can hit or be written back.
    l2_array #(
        .clear_on_rst(1'b1),
        .T(logic)
    ) valid_i (
        .clk,
        .rst,
        .write(ctl.load_v),
        .index,
        .datain(ctl.v_in),
        .dataout(v_out)
    );

    l2_array #(
        .clear_on_rst(1'b1),
        .T(logic)
    ) dirty_i (
        .clk,
        .rst,
        .write(ctl.load_d),
        .index,
        .datain(ctl.d_in),
        .dataout(d_out)
    );

    // tag and line are always written together.
    l2_array #(
        .T(l2_geom_pkg::l2_tag_t)
    ) tag_i (
        .clk,
        .rst,
        .write(ctl.load_td),
        .index,
        .datain(tag_in),
        .dataout(tag_out)
    );

    l2_array #(
        .T(l2_geom_pkg::l2_line_t)
    ) data_i (
        .clk,
        .rst,
        .write(ctl.load_td),
        .index,
        .datain(data_in),
        .dataout(data_out)
    );

endmodule : l2_way

`default_nettype wire

/* src/l2_plru.sv */
`timescale 1ns/10ps
`default_nettype none

// tree pseudo-LRU over eight ways.
// node 0 is the root, nodes 1 and 2 the second level, nodes 3 to 6 the leaves' parents.
// a node bit of 0 sends the victim search to the lower half, 1 to the upper half.
module l2_plru (
    input  logic clk,
    input  logic rst,
    input  logic update,
    input  l2_geom_pkg::l2_index_t index,
    input  l2_geom_pkg::l2_way_t access_way,
    output l2_geom_pkg::l2_way_t victim
);

    logic [l2_geom_pkg::plru_bits-1:0] tree;
    logic [l2_geom_pkg::plru_bits-1:0] tree_next;

    l2_array #(
        .clear_on_rst(1'b1),
        .T(logic [l2_geom_pkg::plru_bits-1:0])
    ) bits_i (
        .clk,
        .rst,
        .write(update),
        .index,
        .datain(tree_next),
        .dataout(tree)
    );

    // walk from the root; each level decides one bit of the way number, msb first.
    always_comb begin
        victim[2] = tree[0];
        victim[1] = tree[1 + victim[2]];
        victim[0] = tree[3 + 2 * victim[2] + victim[1]];
    end

    // every node on the path of the accessed way now points the other way.
    always_comb begin
        tree_next = tree;
        tree_next[0] = ~access_way[2];
        tree_next[1 + access_way[2]] = ~access_way[1];
        tree_next[3 + 2 * access_way[2] + access_way[1]] = ~access_way[0];
    end

endmodule : l2_plru

`default_nettype wire

/* src/l2_cache_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

// storage, hit detection and the muxes toward the arbiter and memory.
module l2_cache_datapath (
    input  logic clk,
    input  logic rst,
    l2_ctl_if.dp ctl,
    input  l2_geom_pkg::l2_addr_t mem_address,
    input  l2_geom_pkg::l2_line_t l2_wdata,
    input  l2_geom_pkg::l2_line_t pmem_rdata,
    output l2_geom_pkg::l2_line_t l2_mem_rdata,
    output l2_geom_pkg::l2_line_t pmem_wdata,
    output l2_geom_pkg::l2_addr_t pmem_address
);

    localparam int unsigned ways = l2_geom_pkg::num_ways;

    l2_geom_pkg::l2_tag_t req_tag;
    l2_geom_pkg::l2_index_t req_index;

    logic [ways-1:0] v_bits;
    logic [ways-1:0] d_bits;
    l2_geom_pkg::l2_tag_t tags [ways];
    l2_geom_pkg::l2_line_t lines [ways];

    l2_geom_pkg::l2_line_t wdata;
    l2_ctl_pkg::l2_way_stat_t [ways-1:0] stat;
    logic hit_any;
    l2_geom_pkg::l2_way_t hit_way;
    l2_geom_pkg::l2_way_t access_way;

    assign req_tag = mem_address[l2_geom_pkg::addr_width-1 -: l2_geom_pkg::tag_bits];
    assign req_index = mem_address[l2_geom_pkg::offset_bits +: l2_geom_pkg::index_bits];

    // a fill installs the memory line, every other load takes the arbiter's line.
    assign wdata = ctl.wdata_from_mem ? pmem_rdata : l2_wdata;

    for (genvar w = 0; w < ways; w++) begin : g_way
        l2_way way_i (
            .clk,
            .rst,
            .ctl(ctl.way_ctl[w]),
            .index(req_index),
            .tag_in(req_tag),
            .data_in(wdata),
            .v_out(v_bits[w]),
            .d_out(d_bits[w]),
            .tag_out(tags[w]),
            .data_out(lines[w])
        );
    end

    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            stat[w].hit = v_bits[w] && (tags[w] == req_tag);
            stat[w].dirty = d_bits[w];
            if (stat[w].hit) begin
                hit_any = 1'b1;
                hit_way = l2_geom_pkg::l2_way_t'(w);
            end
        end
    end

    assign ctl.way_stat = stat;

    // on a miss the victim is the way that is written back and then refilled.
    assign access_way = hit_any ? hit_way : ctl.victim;

    assign l2_mem_rdata = lines[access_way];
    assign pmem_wdata = lines[access_way];

    always_comb begin
        if (ctl.addr_sel == l2_ctl_pkg::sel_victim_tag) begin
            pmem_address = {tags[ctl.victim], req_index, l2_geom_pkg::offset_bits'(0)};
        end else begin
            pmem_address = {req_tag, req_index, l2_geom_pkg::offset_bits'(0)};
        end
    end

    l2_plru plru_i (
        .clk,
        .rst,
        .update(ctl.load_lru),
        .index(req_index),
        .access_way(access_way),
        .victim(ctl.victim)
    );

endmodule : l2_cache_datapath

`default_nettype wire

/* src/l2_cache_control.sv */
`timescale 1ns/10ps
`default_nettype none

// sequences hits, writebacks and fills.
// every access ends with a hit in s_check, except a clean write miss which installs directly.
module l2_cache_control (
    input  logic clk,
    input  logic rst,
    l2_ctl_if.ctrl ctl,
    input  logic mem_read,
    input  logic mem_write,
    input  logic pmem_resp,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write
);

    l2_ctl_pkg::l2_state_e state;
    l2_ctl_pkg::l2_state_e next_state;

    logic hit_any;
    l2_geom_pkg::l2_way_t hit_way;
    l2_geom_pkg::l2_way_t target;
    logic victim_dirty;
    l2_ctl_pkg::l2_way_ctl_t cmd;

    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < l2_geom_pkg::num_ways; w++) begin
            if (ctl.way_stat[w].hit) begin
                hit_any = 1'b1;
                hit_way = l2_geom_pkg::l2_way_t'(w);
            end
        end
    end

    assign victim_dirty = ctl.way_stat[ctl.victim].dirty;

    // commands go to the hit way, or to the victim when nothing hits.
    assign target = hit_any ? hit_way : ctl.victim;

    always_comb begin
        next_state = state;
        cmd = '0;
        mem_resp = 1'b0;
        ctl.load_lru = 1'b0;
        ctl.wdata_from_mem = 1'b0;
        ctl.addr_sel = l2_ctl_pkg::sel_req_addr;

        case (state)
            l2_ctl_pkg::s_check: begin
                if (mem_read || mem_write) begin
                    if (hit_any) begin
                        mem_resp = 1'b1;
                        ctl.load_lru = 1'b1;
                        if (mem_write) begin
                            cmd.load_td = 1'b1;
                            cmd.load_d = 1'b1;
                            cmd.d_in = 1'b1;
                        end
                    end else if (victim_dirty) begin
                        next_state = l2_ctl_pkg::s_writeback;
                    end else if (mem_read) begin
                        next_state = l2_ctl_pkg::s_fill;
                    end else begin
                        // a write carries a whole line, so no fetch is needed.
                        cmd.load_td = 1'b1;
                        cmd.load_v = 1'b1;
                        cmd.v_in = 1'b1;
                        cmd.load_d = 1'b1;
                        cmd.d_in = 1'b1;
                        ctl.load_lru = 1'b1;
                        mem_resp = 1'b1;
                    end
                end
            end

            l2_ctl_pkg::s_writeback: begin
                ctl.addr_sel = l2_ctl_pkg::sel_victim_tag;
                if (pmem_resp) begin
                    cmd.load_d = 1'b1;
                    cmd.d_in = 1'b0;
                    next_state = mem_read ? l2_ctl_pkg::s_fill : l2_ctl_pkg::s_check;
                end
            end

            l2_ctl_pkg::s_fill: begin
                if (pmem_resp) begin
                    ctl.wdata_from_mem = 1'b1;
                    cmd.load_td = 1'b1;
                    cmd.load_v = 1'b1;
                    cmd.v_in = 1'b1;
                    cmd.load_d = 1'b1;
                    cmd.d_in = 1'b0;
                    next_state = l2_ctl_pkg::s_check;
                end
            end

            default: begin
                next_state = l2_ctl_pkg::s_check;
            end
        endcase
    end

    always_comb begin
        ctl.way_ctl = '0;
        ctl.way_ctl[target] = cmd;
    end

    // memory requests are plain levels held for as long as the state lasts.
    assign pmem_write = (state == l2_ctl_pkg::s_writeback);
    assign pmem_read = (state == l2_ctl_pkg::s_fill);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= l2_ctl_pkg::s_check;
        end else begin
            state <= next_state;
        end
    end

endmodule : l2_cache_control

`default_nettype wire

/* src/l2_cache.sv */
`timescale 1ns/10ps
`default_nettype none

// 8-way set-associative write-back second-level cache.
module l2_cache (
    input  logic clk,
    input  logic rst,

    // arbiter side.
    input  logic mem_read,
    input  logic mem_write,
    input  l2_geom_pkg::l2_addr_t mem_address,
    input  l2_geom_pkg::l2_line_t l2_wdata,
    output l2_geom_pkg::l2_line_t l2_mem_rdata,
    output logic mem_resp,

    // physical memory side.
    output logic pmem_read,
    output logic pmem_write,
    output l2_geom_pkg::l2_addr_t pmem_address,
    output l2_geom_pkg::l2_line_t pmem_wdata,
    input  l2_geom_pkg::l2_line_t pmem_rdata,
    input  logic pmem_resp
);

    l2_ctl_if ctl_if ();

    l2_cache_control control_i (
        .clk,
        .rst,
        .ctl(ctl_if.ctrl),
        .mem_read,
        .mem_write,
        .pmem_resp,
        .mem_resp,
        .pmem_read,
        .pmem_write
    );

    l2_cache_datapath datapath_i (
        .clk,
        .rst,
        .ctl(ctl_if.dp),
        .mem_address,
        .l2_wdata,
        .pmem_rdata,
        .l2_mem_rdata,
        .pmem_wdata,
        .pmem_address
    );

endmodule : l2_cache

`default_nettype wire

/* verification/l2_pmem_model.sv */
`timescale 1ns/10ps
`default_nettype none

// physical memory behind the cache.
// a held read or write is answered after a fixed number of cycles with a one-cycle pmem_resp.
// every transaction is counted and the last writeback is kept for the checks.
module l2_pmem_model #(
    parameter logic [31:0] seed = 32'h5a17_c3e9,
    parameter int delay = 3
) (
    input  logic clk,
    input  logic pmem_read,
    input  logic pmem_write,
    input  l2_geom_pkg::l2_addr_t pmem_address,
    input  l2_geom_pkg::l2_line_t pmem_wdata,
    output l2_geom_pkg::l2_line_t pmem_rdata,
    output logic pmem_resp,
    output int read_count,
    output int write_count,
    output l2_geom_pkg::l2_addr_t last_waddr,
    output l2_geom_pkg::l2_line_t last_wdata
);

    localparam int num_lines = 1 << (l2_geom_pkg::addr_width - l2_geom_pkg::offset_bits);

    l2_geom_pkg::l2_line_t mem [num_lines];
    int wait_cycles;

    // each 32-bit word mixes the full line number with the seed.
    function automatic l2_geom_pkg::l2_line_t preload_line(int unsigned line);
        l2_geom_pkg::l2_line_t value;
        for (int w = 0; w < 4; w++) begin
            value[32*w +: 32] = (seed ^ (line * 32'h0001_0193)) + w * 32'h1357_9bdf;
        end
        return value;
    endfunction

    initial begin
        for (int i = 0; i < num_lines; i++) begin
            mem[i] = preload_line(i);
        end
        pmem_rdata = '0;
        pmem_resp = 1'b0;
        read_count = 0;
        write_count = 0;
        last_waddr = '0;
        last_wdata = '0;
        wait_cycles = 0;
    end

    // responses change on the falling edge, like every other input of the cache.
    always @(negedge clk) begin
        if (pmem_resp || !(pmem_read || pmem_write)) begin
            pmem_resp <= 1'b0;
            wait_cycles <= 0;
        end else if (wait_cycles < delay - 1) begin
            wait_cycles <= wait_cycles + 1;
        end else begin
            pmem_resp <= 1'b1;
            wait_cycles <= 0;
            if (pmem_read) begin
                pmem_rdata <= mem[pmem_address >> l2_geom_pkg::offset_bits];
                read_count <= read_count + 1;
            end else begin
                mem[pmem_address >> l2_geom_pkg::offset_bits] <= pmem_wdata;
                write_count <= write_count + 1;
                last_waddr <= pmem_address;
                last_wdata <= pmem_wdata;
            end
        end
    end

endmodule : l2_pmem_model

`default_nettype wire

/* verification/tb_l2_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_l2_cache;

    localparam int rand_accesses = 120;
    localparam int flush_accesses = 32;
    localparam int total_accesses = 2 + 4 + 17 + 21 + rand_accesses + flush_accesses;
    localparam int num_lines = 1 << (l2_geom_pkg::addr_width - l2_geom_pkg::offset_bits);
    localparam int sets = l2_geom_pkg::num_sets;
    localparam int ways = l2_geom_pkg::num_ways;

    logic clk;
    logic rst;
    logic mem_read;
    logic mem_write;
    l2_geom_pkg::l2_addr_t mem_address;
    l2_geom_pkg::l2_line_t l2_wdata;
    l2_geom_pkg::l2_line_t l2_mem_rdata;
    logic mem_resp;
    logic pmem_read;
    logic pmem_write;
    l2_geom_pkg::l2_addr_t pmem_address;
    l2_geom_pkg::l2_line_t pmem_wdata;
    l2_geom_pkg::l2_line_t pmem_rdata;
    logic pmem_resp;
    int read_count;
    int write_count;
    l2_geom_pkg::l2_addr_t last_waddr;
    l2_geom_pkg::l2_line_t last_wdata;

    // expectations for the access in flight, changed only on the falling edge.
    string test_name;
    logic started;
    logic exp_hit;
    logic exp_wb;
    logic exp_fill;
    l2_geom_pkg::l2_addr_t exp_wb_addr;
    l2_geom_pkg::l2_addr_t exp_fill_addr;
    l2_geom_pkg::l2_line_t exp_wb_data;
    l2_geom_pkg::l2_line_t exp_rdata;
    logic resp_q = 1'b0;

    // shadow of memory and of every cache way.
    l2_geom_pkg::l2_line_t shadow_mem [num_lines];
    logic sh_valid [sets][ways];
    logic sh_dirty [sets][ways];
    l2_geom_pkg::l2_tag_t sh_tag [sets][ways];
    l2_geom_pkg::l2_line_t sh_line [sets][ways];
    logic [l2_geom_pkg::plru_bits-1:0] sh_tree [sets];

    l2_cache l2_cache_i (
        .clk, .rst, .mem_read, .mem_write, .mem_address, .l2_wdata, .l2_mem_rdata,
        .mem_resp, .pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_rdata,
        .pmem_resp
    );

    l2_pmem_model pmem_i (
        .clk, .pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_rdata,
        .pmem_resp, .read_count, .write_count, .last_waddr, .last_wdata
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        resp_q <= mem_resp;
    end

    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_value(string what, logic [127:0] expected, logic [127:0] actual);
        stop_run($sformatf("ERROR %s %s: expected %h actual %h",
                           test_name, what, expected, actual));
    endtask

    assert property (@(posedge clk) (started && !mem_read && !mem_write)
                     |-> !mem_resp && !pmem_read && !pmem_write)
        else stop_run("the cache responded or went to memory with no request pending");
    assert property (@(posedge clk) ((mem_read || mem_write) && exp_hit) |-> mem_resp)
        else stop_run($sformatf("%s: a hit did not respond in its first cycle", test_name));
    assert property (@(posedge clk) exp_hit |-> !pmem_read && !pmem_write)
        else stop_run($sformatf("%s: a hit caused memory traffic", test_name));
    assert property (@(posedge clk) (mem_read && mem_resp) |-> l2_mem_rdata == exp_rdata)
        else report_value("read data", $sampled(exp_rdata), $sampled(l2_mem_rdata));
    assert property (@(posedge clk) pmem_read |-> exp_fill)
        else stop_run($sformatf("%s: the cache read memory when no fill was due", test_name));
    assert property (@(posedge clk) pmem_read |-> pmem_address == exp_fill_addr)
        else report_value("fill address", $sampled(exp_fill_addr), $sampled(pmem_address));
    assert property (@(posedge clk) pmem_write |-> exp_wb)
        else stop_run($sformatf("%s: the cache wrote back a line that was clean", test_name));
    assert property (@(posedge clk) pmem_write |-> pmem_address == exp_wb_addr)
        else report_value("writeback address", $sampled(exp_wb_addr), $sampled(pmem_address));
    assert property (@(posedge clk) pmem_write |-> pmem_wdata == exp_wb_data)
        else report_value("writeback data", $sampled(exp_wb_data), $sampled(pmem_wdata));

    // the victim walk follows the direction stored in each node.
    // node n has children 2n+1 and 2n+2.
    function automatic int plru_victim(logic [l2_geom_pkg::plru_bits-1:0] tree);
        int node;
        int way;
        int b;
        node = 0;
        way = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            b = tree[node];
            way = 2 * way + b;
            node = 2 * node + 1 + b;
        end
        return way;
    endfunction

    function automatic logic [l2_geom_pkg::plru_bits-1:0] plru_touch(
        logic [l2_geom_pkg::plru_bits-1:0] tree, int way);
        int node;
        int b;
        node = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            b = (way >> (2 - lvl)) & 1;
            tree[node] = !b;
            node = 2 * node + 1 + b;
        end
        return tree;
    endfunction

    function automatic logic find_way(int set, int tag, output int way);
        way = 0;
        for (int w = 0; w < ways; w++) begin
            if (sh_valid[set][w] && sh_tag[set][w] == tag) begin
                way = w;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic l2_geom_pkg::l2_addr_t make_addr(int tag, int set, int offset);
        return {l2_geom_pkg::l2_tag_t'(tag), l2_geom_pkg::l2_index_t'(set), 4'(offset)};
    endfunction

    function automatic l2_geom_pkg::l2_line_t rand_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // one arbiter request, held until mem_resp, followed by the shadow update.
    task automatic access(logic is_write, l2_geom_pkg::l2_addr_t addr,
                          l2_geom_pkg::l2_line_t data);
        int set;
        int tag;
        int line;
        int way;
        int rd_before;
        int wr_before;
        logic hit;
        set = addr[l2_geom_pkg::offset_bits +: l2_geom_pkg::index_bits];
        tag = addr[l2_geom_pkg::addr_width-1 -: l2_geom_pkg::tag_bits];
        line = addr >> l2_geom_pkg::offset_bits;
        hit = find_way(set, tag, way);
        if (!hit) begin
            way = plru_victim(sh_tree[set]);
        end
        exp_hit = hit;
        exp_wb = !hit && sh_valid[set][way] && sh_dirty[set][way];
        exp_wb_addr = {sh_tag[set][way], l2_geom_pkg::l2_index_t'(set), 4'h0};
        exp_wb_data = sh_line[set][way];
        exp_fill = !hit && !is_write;
        exp_fill_addr = {addr[15:4], 4'h0};
        exp_rdata = hit ? sh_line[set][way] : shadow_mem[line];
        rd_before = read_count;
        wr_before = write_count;
        mem_read = !is_write;
        mem_write = is_write;
        mem_address = addr;
        l2_wdata = data;
        do @(negedge clk); while (!resp_q);
        mem_read = 1'b0;
        mem_write = 1'b0;
        exp_hit = 1'b0;
        assert (read_count == rd_before + int'(exp_fill))
            else report_value("fill reads", rd_before + int'(exp_fill), read_count);
        assert (write_count == wr_before + int'(exp_wb))
            else report_value("writebacks", wr_before + int'(exp_wb), write_count);
        if (exp_wb) begin
            assert (last_waddr == exp_wb_addr)
                else report_value("logged writeback address", exp_wb_addr, last_waddr);
            assert (last_wdata == exp_wb_data)
                else report_value("logged writeback data", exp_wb_data, last_wdata);
            shadow_mem[exp_wb_addr >> l2_geom_pkg::offset_bits] = exp_wb_data;
        end
        if (!hit) begin
            sh_valid[set][way] = 1'b1;
            sh_tag[set][way] = tag;
            sh_dirty[set][way] = 1'b0;
            sh_line[set][way] = shadow_mem[line];
        end
        if (is_write) begin
            sh_line[set][way] = data;
            sh_dirty[set][way] = 1'b1;
        end
        sh_tree[set] = plru_touch(sh_tree[set], way);
    endtask

    initial begin
        int way;
        void'($urandom(78));
        rst = 1'b1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        l2_wdata = '0;
        started = 1'b0;
        exp_hit = 1'b0;
        exp_wb = 1'b0;
        exp_fill = 1'b0;
        exp_wb_addr = '0;
        exp_fill_addr = '0;
        exp_wb_data = '0;
        exp_rdata = '0;
        test_name = "reset";
        for (int s = 0; s < sets; s++) begin
            sh_tree[s] = '0;
            for (int w = 0; w < ways; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w] = '0;
                sh_line[s][w] = '0;
            end
        end
        @(negedge clk);
        started = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_lines; i++) begin
            shadow_mem[i] = pmem_i.mem[i];
        end

        test_name = "read_miss_then_hit";
        access(1'b0, make_addr(3, 1, 4), '0);
        access(1'b0, make_addr(3, 1, 4), '0);

        test_name = "write_then_read";
        access(1'b1, make_addr(3, 1, 8), rand_line());
        access(1'b0, make_addr(3, 1, 0), '0);
        access(1'b1, make_addr(7, 2, 0), rand_line());
        access(1'b0, make_addr(7, 2, 12), '0);

        // eight tags fill set 5, and a ninth one evicts the pseudo-LRU way.
        test_name = "set_fill";
        for (int k = 0; k < 8; k++) begin
            access(1'b0, make_addr(16 + k, 5, 0), '0);
        end
        for (int k = 0; k < 8; k++) begin
            access(1'b0, make_addr(16 + k, 5, 2), '0);
        end
        access(1'b0, make_addr(24, 5, 0), '0);

        test_name = "dirty_eviction";
        for (int k = 0; k < 9; k++) begin
            if (find_way(5, 16 + k, way)) begin
                access(1'b1, make_addr(16 + k, 5, 0), rand_line());
            end
        end
        for (int k = 0; k < 4; k++) begin
            access(1'b0, make_addr(32 + k, 5, 0), '0);
        end

        test_name = "clean_eviction";
        for (int k = 0; k < 9; k++) begin
            access(1'b0, make_addr(40 + k, 6, 0), '0);
        end

        test_name = "random";
        for (int n = 0; n < rand_accesses; n++) begin
            access(1'($urandom() % 2),
                   make_addr(64 + $urandom() % 12, $urandom() % 4, $urandom() % 16),
                   rand_line());
        end

        // eight new tags per set push every line of that set out to memory.
        test_name = "flush";
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 8; k++) begin
                access(1'b0, make_addr(128 + k, s, 0), '0);
            end
        end
        for (int i = 0; i < num_lines; i++) begin
            assert (pmem_i.mem[i] == shadow_mem[i])
                else report_value($sformatf("memory line %0d", i), shadow_mem[i], pmem_i.mem[i]);
        end

        $display("TEST PASSED");
        $finish;
    end

    // each access needs well under 20 cycles, even a dirty miss with its fill.
    initial begin
        repeat (5 + total_accesses * 20) @(posedge clk);
        stop_run("watchdog expired, the cache stopped answering requests");
    end

endmodule : tb_l2_cache

`default_nettype wire

/* all.f */
src/l2_geom_pkg.sv
src/l2_ctl_pkg.sv
src/l2_ctl_if.sv
src/l2_array.sv
src/l2_way.sv
src/l2_plru.sv
src/l2_cache_datapath.sv
src/l2_cache_control.sv
src/l2_cache.sv
verification/l2_pmem_model.sv
verification/tb_l2_cache.sv
